// ==== bench/controlUnitTb.sv ====
`default_nettype none

module controlUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    import controlPkg::*;

    typedef logic [19:0] ctrlVecT;   // {regDst, 9 flags, dataType, hiLo, aluCtrl}

    localparam int testCount = 55;
    localparam int timeoutNs = (testCount + 4 + 20) * 8;

    // Flag bits in output order
    localparam logic [8:0] fAluSrc   = 9'b100000000;
    localparam logic [8:0] fAluSrc2  = 9'b010000000;
    localparam logic [8:0] fMemToReg = 9'b001000000;
    localparam logic [8:0] fRegWrite = 9'b000100000;
    localparam logic [8:0] fMemRead  = 9'b000010000;
    localparam logic [8:0] fMemWrite = 9'b000001000;
    localparam logic [8:0] fBranch   = 9'b000000100;
    localparam logic [8:0] fJump     = 9'b000000010;
    localparam logic [8:0] fSignExt  = 9'b000000001;

    logic clk;
    logic rstN;
    instrT instr;
    regDstT regDst;
    logic aluSrc;
    logic aluSrc2;
    logic memToReg;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic branch;
    logic jump;
    logic signExtend;
    dataTypeT dataType;
    hiLoT hiLoWrite;
    aluCtrlT aluCtrl;
    ctrlVecT actualCtrl;
    ctrlVecT prevCtrl;
    logic [15:0] lfsrState;
    int errorCount;
    int checkCount;

    controlUnit UUT (.*);

    bind controlUnit controlUnitAssert uControlAssert (.*);

    assign actualCtrl = {regDst, aluSrc, aluSrc2, memToReg, regWrite, memRead, memWrite,
                         branch, jump, signExtend, dataType, hiLoWrite, aluCtrl};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #timeoutNs;
        $display("Timeout: the tests did not finish within %0d ns", timeoutNs);
        $display("TEST FAIL");
        $finish;
    end

    task automatic checkValue(input string what, input ctrlVecT actual, input ctrlVecT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0.1f ns: %s got %05h expected %05h",
                     $realtime, what, actual, expected);
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11, one step per bit
    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic regFieldT anyField();
        logic [31:0] r;
        r = lfsrBits(5);
        return r[4:0];
    endfunction

    // Instruction builders fill unused fields from the LFSR
    function automatic instrT specialInstr(input functT f, input regFieldT sa);
        logic [31:0] r;
        r = lfsrBits(15);                // rs, rt, rd
        return {opSpecial, r[14:0], sa, f};
    endfunction

    function automatic instrT immInstr(input opcodeT op, input regFieldT rtField);
        logic [31:0] r;
        r = lfsrBits(21);                // rs and immediate
        return {op, r[20:16], rtField, r[15:0]};
    endfunction

    function automatic instrT jumpInstr(input opcodeT op);
        logic [31:0] r;
        r = lfsrBits(26);
        return {op, r[25:0]};
    endfunction

    function automatic instrT special2Instr(input functT f);
        logic [31:0] r;
        r = lfsrBits(20);
        return {opSpecial2, r[19:0], f};
    endfunction

    function automatic instrT special3Instr(input regFieldT sa);
        logic [31:0] r;
        r = lfsrBits(15);
        return {opSpecial3, r[14:0], sa, 6'b100000};
    endfunction

    function automatic instrT withBit21(input instrT w, input logic b);
        w[21] = b;
        return w;
    endfunction

    function automatic ctrlVecT makeCtrl(input regDstT rd, input logic [8:0] flags,
                                         input dataTypeT dt, input hiLoT hl, input aluCtrlT alu);
        return {rd, flags, dt, hl, alu};
    endfunction

    // Register-format result writes rd
    function automatic ctrlVecT rdCtrl(input aluCtrlT alu, input hiLoT hl,
                                       input logic [8:0] extra);
        return makeCtrl(regDstRd, fRegWrite | extra, dataWord, hl, alu);
    endfunction

    // Immediate-format result with rt as destination
    function automatic ctrlVecT rtCtrl(input logic [8:0] flags, input dataTypeT dt,
                                       input aluCtrlT alu);
        return makeCtrl(regDstRt, flags, dt, hiLoNone, alu);
    endfunction

    // Old result must hold until the edge that loads the new word
    task automatic runInstr(input string name, input instrT word, input ctrlVecT exp);
        instr = word;
        #5;
        checkValue({name, " previous result held"}, actualCtrl, prevCtrl);
        @(posedge clk);
        #1;
        checkValue(name, actualCtrl, exp);
        prevCtrl = exp;
    endtask

    task automatic undefinedCodes();
        runInstr("undefined opcode", jumpInstr(6'b110000), rtCtrl('0, dataWord, aluNop));
        runInstr("undefined funct", specialInstr(6'b111111, anyField()),
                 rdCtrl(aluNop, hiLoNone, '0));
    endtask

    task automatic specialAluGroup();
        runInstr("add", specialInstr(functAdd, anyField()), rdCtrl(aluAdd, hiLoNone, '0));
        runInstr("addu", specialInstr(functAddu, anyField()), rdCtrl(aluAdd, hiLoNone, '0));
        runInstr("sub", specialInstr(functSub, anyField()), rdCtrl(aluSub, hiLoNone, '0));
        runInstr("and", specialInstr(functAnd, anyField()), rdCtrl(aluAnd, hiLoNone, '0));
        runInstr("or", specialInstr(functOr, anyField()), rdCtrl(aluOr, hiLoNone, '0));
        runInstr("nor", specialInstr(functNor, anyField()), rdCtrl(aluNor, hiLoNone, '0));
        runInstr("xor", specialInstr(functXor, anyField()), rdCtrl(aluXor, hiLoNone, '0));
        runInstr("slt", specialInstr(functSlt, anyField()), rdCtrl(aluSlt, hiLoNone, '0));
        runInstr("sltu", specialInstr(functSltu, anyField()), rdCtrl(aluSltu, hiLoNone, '0));
        runInstr("movn", specialInstr(functMovn, anyField()), rdCtrl(aluMovn, hiLoNone, '0));
        runInstr("movz", specialInstr(functMovz, anyField()), rdCtrl(aluMovz, hiLoNone, '0));
        runInstr("mfhi", specialInstr(functMfhi, anyField()), rdCtrl(aluMfhi, hiLoNone, '0));
        runInstr("mflo", specialInstr(functMflo, anyField()), rdCtrl(aluMflo, hiLoNone, '0));
    endtask

    task automatic shiftsAndRotates();
        runInstr("sll", specialInstr(functSll, anyField()),
                 rdCtrl(aluSll, hiLoNone, fAluSrc2));
        runInstr("srl", withBit21(specialInstr(functSrl, anyField()), 1'b0),
                 rdCtrl(aluSrl, hiLoNone, fAluSrc2));
        runInstr("rotr", withBit21(specialInstr(functSrl, anyField()), 1'b1),
                 rdCtrl(aluRotr, hiLoNone, fAluSrc2));
        runInstr("sllv", specialInstr(functSllv, anyField()), rdCtrl(aluSll, hiLoNone, '0));
        runInstr("srlv", specialInstr(functSrlv, shamtSrlv), rdCtrl(aluSrl, hiLoNone, '0));
        runInstr("rotrv", specialInstr(functSrlv, shamtRotrv), rdCtrl(aluRotr, hiLoNone, '0));
        runInstr("sra", specialInstr(functSra, anyField()), rdCtrl(aluSra, hiLoNone, '0));
        runInstr("srav", specialInstr(functSrav, anyField()), rdCtrl(aluSra, hiLoNone, '0));
    endtask

    task automatic hiLoWrites();
        runInstr("mult", specialInstr(functMult, anyField()), rdCtrl(aluMult, hiLoBoth, '0));
        runInstr("multu", specialInstr(functMultu, anyField()), rdCtrl(aluMult, hiLoBoth, '0));
        runInstr("madd", special2Instr(functMadd), rdCtrl(aluMadd, hiLoBoth, '0));
        runInstr("msub", special2Instr(functMsub), rdCtrl(aluMsub, hiLoBoth, '0));
        runInstr("mthi", specialInstr(functMthi, anyField()), rdCtrl(aluMthi, hiLoHi, '0));
        runInstr("mtlo", specialInstr(functMtlo, anyField()), rdCtrl(aluMtlo, hiLoLo, '0));
        runInstr("mul", special2Instr(functMul), rdCtrl(aluMul, hiLoNone, '0));
    endtask

    task automatic memoryAndImmediates();
        logic [8:0] ld;
        logic [8:0] st;
        logic [8:0] imm;
        ld = fAluSrc | fMemToReg | fRegWrite | fMemRead;
        st = fAluSrc | fMemWrite;
        imm = fAluSrc | fRegWrite;
        runInstr("lw", immInstr(opLw, anyField()), rtCtrl(ld, dataWord, aluNop));
        runInstr("lh", immInstr(opLh, anyField()), rtCtrl(ld, dataHalf, aluNop));
        runInstr("lb", immInstr(opLb, anyField()), rtCtrl(ld, dataByte, aluNop));
        runInstr("sw", immInstr(opSw, anyField()), rtCtrl(st, dataWord, aluNop));
        runInstr("sh", immInstr(opSh, anyField()), rtCtrl(st, dataHalf, aluNop));
        runInstr("sb", immInstr(opSb, anyField()), rtCtrl(st, dataByte, aluNop));
        runInstr("lui", immInstr(opLui, anyField()), rtCtrl(imm, dataWord, aluNop));
        runInstr("addi", immInstr(opAddi, anyField()), rtCtrl(imm, dataWord, aluNop));
        runInstr("addiu", immInstr(opAddiu, anyField()), rtCtrl(imm, dataWord, aluNop));
        runInstr("slti", immInstr(opSlti, anyField()), rtCtrl(imm, dataWord, aluNop));
        runInstr("sltiu", immInstr(opSltiu, anyField()), rtCtrl(imm, dataWord, aluNop));
        runInstr("andi", immInstr(opAndi, anyField()), rtCtrl(imm | fSignExt, dataWord, aluNop));
        runInstr("ori", immInstr(opOri, anyField()), rtCtrl(imm | fSignExt, dataWord, aluNop));
        runInstr("xori", immInstr(opXori, anyField()), rtCtrl(imm | fSignExt, dataWord, aluNop));
    endtask

    task automatic branchesAndJumps();
        runInstr("bgez", immInstr(opRegimm, rtBgez), rtCtrl(fBranch, dataWord, aluBgez));
        runInstr("bltz", immInstr(opRegimm, rtBltz), rtCtrl(fBranch, dataWord, aluBltz));
        runInstr("beq", immInstr(opBeq, anyField()), rtCtrl(fBranch, dataWord, aluNop));
        runInstr("bne", immInstr(opBne, anyField()), rtCtrl(fBranch, dataWord, aluNop));
        runInstr("bgtz", immInstr(opBgtz, anyField()), rtCtrl(fBranch, dataWord, aluNop));
        runInstr("blez", immInstr(opBlez, anyField()), rtCtrl(fBranch, dataWord, aluNop));
        runInstr("j", jumpInstr(opJ), rtCtrl(fAluSrc2 | fJump, dataWord, aluNop));
        runInstr("jr", specialInstr(functJr, anyField()), rdCtrl(aluNop, hiLoNone, fJump));
        runInstr("jal", jumpInstr(opJal),
                 makeCtrl(regDstRa, fAluSrc2 | fJump | fRegWrite, dataWord, hiLoNone, aluNop));
        runInstr("seh", special3Instr(shamtSeh), rdCtrl(aluSeh, hiLoNone, '0));
        runInstr("seb", special3Instr(shamtSeb), rdCtrl(aluSeb, hiLoNone, '0));
    endtask

    initial begin
        rstN = 1'b0;
        instr = '0;
        prevCtrl = '0;
        lfsrState = 16'd76;
        errorCount = 0;
        checkCount = 0;
        repeat (4) @(posedge clk);
        #1;
        checkValue("reset", actualCtrl, '0);
        rstN = 1'b1;                     // Outputs stay zero until the next edge
        undefinedCodes();
        specialAluGroup();
        shiftsAndRotates();
        hiLoWrites();
        memoryAndImmediates();
        branchesAndJumps();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/controlUnitTb_assert.sv ====
`default_nettype none

module controlUnitAssert (
    input logic                 clk,
    input logic                 rstN,
    input controlPkg::regDstT   regDst,
    input logic                 aluSrc,
    input logic                 aluSrc2,
    input logic                 memToReg,
    input logic                 regWrite,
    input logic                 memRead,
    input logic                 memWrite,
    input logic                 branch,
    input logic                 jump,
    input logic                 signExtend,
    input controlPkg::dataTypeT dataType,
    input controlPkg::hiLoT     hiLoWrite,
    input controlPkg::aluCtrlT  aluCtrl
);

    timeunit 1ns;
    timeprecision 100ps;

    memExclusive: assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite))
        else $error("memRead and memWrite are both high");

    flowExclusive: assert property (@(posedge clk) disable iff (!rstN) !(branch && jump))
        else $error("branch and jump are both high");

    // Load data only comes back from a read
    loadNeedsRead: assert property (@(posedge clk) disable iff (!rstN) memToReg |-> memRead)
        else $error("memToReg is high without memRead");

    resetQuiet: assert property (@(posedge clk) !rstN |-> ({regDst, aluSrc, aluSrc2, memToReg,
        regWrite, memRead, memWrite, branch, jump, signExtend, dataType, hiLoWrite,
        aluCtrl} == '0))
        else $error("control outputs are not zero during reset");

endmodule

`default_nettype wire

// ==== controlUnit.f ====
src/controlPkg.sv
src/opcodeDecoder.sv
src/aluFunctDecoder.sv
src/controlUnit.sv
bench/controlUnitTb_assert.sv
bench/controlUnitTb.sv

// ==== src/aluFunctDecoder.sv ====
`default_nettype none

module aluFunctDecoder (
    input  controlPkg::functT    funct,
    input  logic                 bit21,
    input  controlPkg::regFieldT shamt,
    output controlPkg::aluCtrlT  functAluCtrl,
    output controlPkg::hiLoT     functHiLoWrite,
    output logic                 functAluSrc2,
    output logic                 functJump
);

    import controlPkg::*;

    always_comb begin
        functAluCtrl   = aluNop;
        functHiLoWrite = hiLoNone;
        functAluSrc2   = 1'b0;
        functJump      = 1'b0;

        case (funct)
            functAdd, functAddu: functAluCtrl = aluAdd;
            functSub:            functAluCtrl = aluSub;
            functAnd:            functAluCtrl = aluAnd;
            functOr:             functAluCtrl = aluOr;
            functNor:            functAluCtrl = aluNor;
            functXor:            functAluCtrl = aluXor;
            functSlt:            functAluCtrl = aluSlt;
            functSltu:           functAluCtrl = aluSltu;
            functMovn:           functAluCtrl = aluMovn;
            functMovz:           functAluCtrl = aluMovz;
            functMfhi:           functAluCtrl = aluMfhi;
            functMflo:           functAluCtrl = aluMflo;

            functMult, functMultu: begin
                functAluCtrl   = aluMult;
                functHiLoWrite = hiLoBoth;     // 64-bit product
            end

            functMthi: begin
                functAluCtrl   = aluMthi;
                functHiLoWrite = hiLoHi;
            end

            functMtlo: begin
                functAluCtrl   = aluMtlo;
                functHiLoWrite = hiLoLo;
            end

            // Shift amount taken from the shamt field
            functSll: begin
                functAluCtrl = aluSll;
                functAluSrc2 = 1'b1;
            end

            functSrl: begin
                functAluCtrl = bit21 ? aluRotr : aluSrl;
                functAluSrc2 = 1'b1;
            end

            // Variable forms shift by rs
            functSllv: functAluCtrl = aluSll;

            functSrlv: begin
                case (shamt)
                    shamtSrlv:  functAluCtrl = aluSrl;
                    shamtRotrv: functAluCtrl = aluRotr;
                    default:    functAluCtrl = aluNop;
                endcase
            end

            // The reference datapath treats sra like srav with rs as the amount
            functSra, functSrav: functAluCtrl = aluSra;

            functJr: begin
                functAluCtrl = aluNop;
                functJump    = 1'b1;
            end

            default: functAluCtrl = aluNop;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/controlPkg.sv ====
`default_nettype none

package controlPkg;

    typedef logic [31:0] instrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  regFieldT;    // rt or shamt field
    typedef logic [4:0]  aluCtrlT;
    typedef logic [1:0]  hiLoT;
    typedef logic [1:0]  regDstT;
    typedef logic [1:0]  dataTypeT;

    // Primary opcodes
    localparam opcodeT opSpecial  = 6'b000000;
    localparam opcodeT opRegimm   = 6'b000001;   // bgez and bltz
    localparam opcodeT opJ        = 6'b000010;
    localparam opcodeT opJal      = 6'b000011;
    localparam opcodeT opBeq      = 6'b000100;
    localparam opcodeT opBne      = 6'b000101;
    localparam opcodeT opBlez     = 6'b000110;
    localparam opcodeT opBgtz     = 6'b000111;
    localparam opcodeT opAddi     = 6'b001000;
    localparam opcodeT opAddiu    = 6'b001001;
    localparam opcodeT opSlti     = 6'b001010;
    localparam opcodeT opSltiu    = 6'b001011;
    localparam opcodeT opAndi     = 6'b001100;
    localparam opcodeT opOri      = 6'b001101;
    localparam opcodeT opXori     = 6'b001110;
    localparam opcodeT opLui      = 6'b001111;
    localparam opcodeT opSpecial2 = 6'b011100;   // mul, madd, msub
    localparam opcodeT opSpecial3 = 6'b011111;   // seh, seb
    localparam opcodeT opLb       = 6'b100000;
    localparam opcodeT opLh       = 6'b100001;
    localparam opcodeT opLw       = 6'b100011;
    localparam opcodeT opSb       = 6'b101000;
    localparam opcodeT opSh       = 6'b101001;
    localparam opcodeT opSw       = 6'b101011;

    // SPECIAL funct values
    localparam functT functSll   = 6'b000000;
    localparam functT functSrl   = 6'b000010;    // rotr when bit 21 is set
    localparam functT functSra   = 6'b000011;
    localparam functT functSllv  = 6'b000100;
    localparam functT functSrlv  = 6'b000110;    // rotrv when shamt is 1
    localparam functT functSrav  = 6'b000111;
    localparam functT functJr    = 6'b001000;
    localparam functT functMovz  = 6'b001010;
    localparam functT functMovn  = 6'b001011;
    localparam functT functMfhi  = 6'b010000;
    localparam functT functMthi  = 6'b010001;
    localparam functT functMflo  = 6'b010010;
    localparam functT functMtlo  = 6'b010011;
    localparam functT functMult  = 6'b011000;
    localparam functT functMultu = 6'b011001;
    localparam functT functAdd   = 6'b100000;
    localparam functT functAddu  = 6'b100001;
    localparam functT functSub   = 6'b100010;
    localparam functT functAnd   = 6'b100100;
    localparam functT functOr    = 6'b100101;
    localparam functT functXor   = 6'b100110;
    localparam functT functNor   = 6'b100111;
    localparam functT functSlt   = 6'b101010;
    localparam functT functSltu  = 6'b101011;

    // SPECIAL2 funct values
    localparam functT functMadd  = 6'b000000;
    localparam functT functMul   = 6'b000010;
    localparam functT functMsub  = 6'b000100;

    // Sub-field selectors
    localparam regFieldT rtBltz     = 5'b00000;
    localparam regFieldT rtBgez     = 5'b00001;
    localparam regFieldT shamtSrlv  = 5'b00000;
    localparam regFieldT shamtRotrv = 5'b00001;
    localparam regFieldT shamtSeh   = 5'b11000;
    localparam regFieldT shamtSeb   = 5'b10000;

    // ALU operation codes, same numbering as the datapath ALU
    localparam aluCtrlT aluAdd  = 5'b00000;
    localparam aluCtrlT aluSub  = 5'b00001;
    localparam aluCtrlT aluMult = 5'b00010;
    localparam aluCtrlT aluAnd  = 5'b00011;
    localparam aluCtrlT aluOr   = 5'b00100;
    localparam aluCtrlT aluNor  = 5'b00101;
    localparam aluCtrlT aluXor  = 5'b00110;
    localparam aluCtrlT aluSll  = 5'b00111;
    localparam aluCtrlT aluSrl  = 5'b01000;
    localparam aluCtrlT aluRotr = 5'b01001;
    localparam aluCtrlT aluSlt  = 5'b01010;
    localparam aluCtrlT aluMovn = 5'b01011;
    localparam aluCtrlT aluMovz = 5'b01100;
    localparam aluCtrlT aluSra  = 5'b01101;
    localparam aluCtrlT aluSltu = 5'b01110;
    localparam aluCtrlT aluMthi = 5'b01111;
    localparam aluCtrlT aluMtlo = 5'b10000;
    localparam aluCtrlT aluMfhi = 5'b10001;
    localparam aluCtrlT aluMflo = 5'b10010;
    localparam aluCtrlT aluMul  = 5'b10011;      // 32-bit result, no HI/LO
    localparam aluCtrlT aluMadd = 5'b10100;
    localparam aluCtrlT aluMsub = 5'b10101;
    localparam aluCtrlT aluSeh  = 5'b10110;
    localparam aluCtrlT aluSeb  = 5'b10111;
    localparam aluCtrlT aluBgez = 5'b11000;
    localparam aluCtrlT aluBltz = 5'b11001;
    localparam aluCtrlT aluNop  = 5'b11111;

    // HI/LO write enables
    localparam hiLoT hiLoNone = 2'd0;
    localparam hiLoT hiLoHi   = 2'd1;
    localparam hiLoT hiLoLo   = 2'd2;
    localparam hiLoT hiLoBoth = 2'd3;

    // Destination register select
    localparam regDstT regDstRt = 2'd0;
    localparam regDstT regDstRd = 2'd1;
    localparam regDstT regDstRa = 2'd2;          // link register for jal

    // Load and store width
    localparam dataTypeT dataWord = 2'd0;
    localparam dataTypeT dataHalf = 2'd1;
    localparam dataTypeT dataByte = 2'd2;

endpackage

`default_nettype wire

// ==== src/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  controlPkg::instrT    instr,
    output controlPkg::regDstT   regDst,
    output logic                 aluSrc,
    output logic                 aluSrc2,
    output logic                 memToReg,
    output logic                 regWrite,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 branch,
    output logic                 jump,
    output logic                 signExtend,
    output controlPkg::dataTypeT dataType,
    output controlPkg::hiLoT     hiLoWrite,
    output controlPkg::aluCtrlT  aluCtrl
);

    import controlPkg::*;

    // Instruction fields
    opcodeT   opcode;
    regFieldT rt;
    logic     bit21;
    regFieldT shamt;
    functT    funct;

    // Opcode decoder results
    regDstT   decRegDst;
    logic     decAluSrc;
    logic     decAluSrc2;
    logic     decMemToReg;
    logic     decRegWrite;
    logic     decMemRead;
    logic     decMemWrite;
    logic     decBranch;
    logic     decJump;
    logic     decSignExtend;
    dataTypeT decDataType;
    hiLoT     decHiLoWrite;
    aluCtrlT  decAluCtrl;
    logic     useFunct;

    // Funct decoder results
    aluCtrlT  functAluCtrl;
    hiLoT     functHiLoWrite;
    logic     functAluSrc2;
    logic     functJump;

    assign opcode = instr[31:26];
    assign bit21  = instr[21];
    assign rt     = instr[20:16];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];

    opcodeDecoder uOpcodeDecoder (
        .opcode     (opcode),
        .rt         (rt),
        .shamt      (shamt),
        .funct      (funct),
        .regDst     (decRegDst),
        .aluSrc     (decAluSrc),
        .aluSrc2    (decAluSrc2),
        .memToReg   (decMemToReg),
        .regWrite   (decRegWrite),
        .memRead    (decMemRead),
        .memWrite   (decMemWrite),
        .branch     (decBranch),
        .jump       (decJump),
        .signExtend (decSignExtend),
        .dataType   (decDataType),
        .hiLoWrite  (decHiLoWrite),
        .aluCtrl    (decAluCtrl),
        .useFunct   (useFunct)
    );

    aluFunctDecoder uAluFunctDecoder (
        .funct          (funct),
        .bit21          (bit21),
        .shamt          (shamt),
        .functAluCtrl   (functAluCtrl),
        .functHiLoWrite (functHiLoWrite),
        .functAluSrc2   (functAluSrc2),
        .functJump      (functJump)
    );

    // ID/EX style output register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regDst     <= '0;
            aluSrc     <= 1'b0;
            aluSrc2    <= 1'b0;
            memToReg   <= 1'b0;
            regWrite   <= 1'b0;
            memRead    <= 1'b0;
            memWrite   <= 1'b0;
            branch     <= 1'b0;
            jump       <= 1'b0;
            signExtend <= 1'b0;
            dataType   <= '0;
            hiLoWrite  <= '0;
            aluCtrl    <= '0;
        end else begin
            regDst     <= decRegDst;
            aluSrc     <= decAluSrc;
            memToReg   <= decMemToReg;
            regWrite   <= decRegWrite;
            memRead    <= decMemRead;
            memWrite   <= decMemWrite;
            branch     <= decBranch;
            signExtend <= decSignExtend;
            dataType   <= decDataType;
            // SPECIAL takes these four from the funct decoder
            aluSrc2    <= useFunct ? functAluSrc2 : decAluSrc2;
            jump       <= useFunct ? functJump : decJump;
            hiLoWrite  <= useFunct ? functHiLoWrite : decHiLoWrite;
            aluCtrl    <= useFunct ? functAluCtrl : decAluCtrl;
        end
    end

endmodule

`default_nettype wire

// ==== src/opcodeDecoder.sv ====
`default_nettype none

module opcodeDecoder (
    input  controlPkg::opcodeT   opcode,
    input  controlPkg::regFieldT rt,
    input  controlPkg::regFieldT shamt,
    input  controlPkg::functT    funct,
    output controlPkg::regDstT   regDst,
    output logic                 aluSrc,
    output logic                 aluSrc2,
    output logic                 memToReg,
    output logic                 regWrite,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 branch,
    output logic                 jump,
    output logic                 signExtend,
    output controlPkg::dataTypeT dataType,
    output controlPkg::hiLoT     hiLoWrite,
    output controlPkg::aluCtrlT  aluCtrl,
    output logic                 useFunct
);

    import controlPkg::*;

    always_comb begin
        // Everything inactive unless an opcode below says otherwise
        regDst     = regDstRt;
        aluSrc     = 1'b0;
        aluSrc2    = 1'b0;
        memToReg   = 1'b0;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        signExtend = 1'b0;
        dataType   = dataWord;
        hiLoWrite  = hiLoNone;
        aluCtrl    = aluNop;
        useFunct   = 1'b0;

        case (opcode)
            opSpecial: begin
                // ALU code, HI/LO, shift source and jr come from the funct decoder
                useFunct = 1'b1;
                regDst   = regDstRd;
                regWrite = 1'b1;
            end

            opSpecial2: begin
                regDst   = regDstRd;
                regWrite = 1'b1;
                case (funct)
                    functMul: aluCtrl = aluMul;
                    functMadd: begin
                        aluCtrl   = aluMadd;
                        hiLoWrite = hiLoBoth;
                    end
                    functMsub: begin
                        aluCtrl   = aluMsub;
                        hiLoWrite = hiLoBoth;
                    end
                    default: aluCtrl = aluNop;
                endcase
            end

            opLw, opLh, opLb: begin
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                if (opcode == opLh)
                    dataType = dataHalf;
                else if (opcode == opLb)
                    dataType = dataByte;
            end

            opSw, opSh, opSb: begin
                aluSrc   = 1'b1;       // Base plus offset
                memWrite = 1'b1;
                if (opcode == opSh)
                    dataType = dataHalf;
                else if (opcode == opSb)
                    dataType = dataByte;
            end

            opLui: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end

            opRegimm: begin
                branch = 1'b1;
                case (rt)
                    rtBgez:  aluCtrl = aluBgez;
                    rtBltz:  aluCtrl = aluBltz;
                    default: aluCtrl = aluNop;
                endcase
            end

            // Compare is done outside the ALU for these
            opBeq, opBne, opBgtz, opBlez: branch = 1'b1;

            opAddi, opAddiu, opSlti, opSltiu: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end

            opAndi, opOri, opXori: begin
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
                signExtend = 1'b1;     // Extension select for logical immediates
            end

            opSpecial3: begin
                regDst   = regDstRd;
                regWrite = 1'b1;
                case (shamt)
                    shamtSeh: aluCtrl = aluSeh;
                    shamtSeb: aluCtrl = aluSeb;
                    default:  aluCtrl = aluNop;
                endcase
            end

            opJ: begin
                aluSrc2 = 1'b1;
                jump    = 1'b1;
            end

            opJal: begin
                regDst   = regDstRa;   // Return address into r31
                aluSrc2  = 1'b1;
                regWrite = 1'b1;
                jump     = 1'b1;
            end

            default: aluCtrl = aluNop;
        endcase
    end

endmodule

`default_nettype wire
